/* rtl/mmio_defs.svh */
`ifndef MMIO_DEFS_SVH
`define MMIO_DEFS_SVH

////////////////////////////////////////
// Bus and address widths
////////////////////////////////////////

// Processor physical address
`define PADDR_WIDTH       40
// One mesh word
`define DATA_WIDTH        32
// Processor memory-bus data
`define FILL_WIDTH        64
// Mesh word address
`define MC_ADDR_WIDTH     28

////////////////////////////////////////
// Mesh coordinates
////////////////////////////////////////

`define X_CORD_WIDTH      7
`define Y_CORD_WIDTH      7
// Y splits into pod and sub-pod parts
`define POD_Y_WIDTH       4
`define Y_SUBCORD_WIDTH   3
`define REG_ID_WIDTH      5

// Transaction slots
`define OUTSTANDING       4
`define TRANS_ID_WIDTH    2

// Byte offsets inside each target
`define TILE_ADDR_WIDTH   18
`define VCACHE_ADDR_WIDTH 29

// Top two address bits select the target
`define REGION_TILE       2'b11
`define REGION_VCACHE     2'b10

`endif

/* rtl/bedrock_pkg.sv */
`include "mmio_defs.svh"

package bedrock_pkg;

  ////////////////////////////////////////
  // Processor memory-bus message fields
  ////////////////////////////////////////

  // Message type
  typedef enum logic [3:0]
  {
    e_bedrock_mem_rd    = 4'b0000,
    e_bedrock_mem_wr    = 4'b0001,
    e_bedrock_mem_uc_rd = 4'b0010,
    e_bedrock_mem_uc_wr = 4'b0011,
    e_bedrock_mem_amo   = 4'b0101
  } bedrock_msg_e;

  // Access size, log2 of the byte count
  typedef enum logic [2:0]
  {
    e_bedrock_msg_size_1 = 3'b000,
    e_bedrock_msg_size_2 = 3'b001,
    e_bedrock_msg_size_4 = 3'b010,
    e_bedrock_msg_size_8 = 3'b011
  } bedrock_size_e;

  // Atomic subops carried on amo messages
  typedef enum logic [3:0]
  {
    e_bedrock_amoswap = 4'b0001,
    e_bedrock_amoadd  = 4'b0010,
    e_bedrock_amoor   = 4'b0100
  } bedrock_amo_e;

  // Header for both request and response, tag comes back unchanged
  typedef struct packed
  {
    bedrock_msg_e               msg_type;
    bedrock_amo_e               subop;
    bedrock_size_e              size;
    logic [`PADDR_WIDTH-1:0]    addr;
    logic [15:0]                tag;
  } bedrock_hdr_t;

endpackage

/* rtl/manycore_pkg.sv */
`include "mmio_defs.svh"

package manycore_pkg;

  ////////////////////////////////////////
  // Mesh request encoding
  ////////////////////////////////////////

  // Store is a full word, sw carries a byte mask
  typedef enum logic [3:0]
  {
    e_remote_load    = 4'd0,
    e_remote_store   = 4'd1,
    e_remote_sw      = 4'd2,
    e_remote_amoswap = 4'd4,
    e_remote_amoor   = 4'd5,
    e_remote_amoadd  = 4'd6
  } mc_op_e;

  // Sub-word load description
  typedef struct packed
  {
    logic       is_byte_op;
    logic       is_hex_op;
    logic [1:0] part_sel;
  } mc_load_info_t;

  typedef struct packed
  {
    mc_op_e                        op;
    logic [`MC_ADDR_WIDTH-1:0]     addr;
    logic [`DATA_WIDTH-1:0]        payload;
    logic [(`DATA_WIDTH/8)-1:0]    store_mask;
    mc_load_info_t                 load_info;
    logic [`REG_ID_WIDTH-1:0]      reg_id;
    logic [`Y_CORD_WIDTH-1:0]      y_cord;
    logic [`X_CORD_WIDTH-1:0]      x_cord;
    logic [`Y_CORD_WIDTH-1:0]      src_y_cord;
    logic [`X_CORD_WIDTH-1:0]      src_x_cord;
  } mc_packet_t;

  ////////////////////////////////////////
  // Mesh return encoding
  ////////////////////////////////////////

  // Credit for stores, int_wb for anything with read data
  typedef enum logic [1:0]
  {
    e_return_credit = 2'd0,
    e_return_int_wb = 2'd1
  } mc_return_type_e;

  typedef struct packed
  {
    mc_return_type_e               pkt_type;
    logic [`DATA_WIDTH-1:0]        data;
    logic [`REG_ID_WIDTH-1:0]      reg_id;
  } mc_return_t;

endpackage

/* rtl/fwd_decoder.sv */
`timescale 1ns/100ps
`include "mmio_defs.svh"

module fwd_decoder
  (
    input  bedrock_pkg::bedrock_hdr_t        hdr_i,
    input  logic [`FILL_WIDTH-1:0]           data_i,
    input  logic [`TRANS_ID_WIDTH-1:0]       alloc_id_i,
    input  logic [`X_CORD_WIDTH-1:0]         host_x_i,
    input  logic [`Y_CORD_WIDTH-1:0]         host_y_i,
    input  logic [`X_CORD_WIDTH-1:0]         global_x_i,
    input  logic [`Y_CORD_WIDTH-1:0]         global_y_i,
    output manycore_pkg::mc_packet_t         packet_o
  );

  import bedrock_pkg::*;
  import manycore_pkg::*;

  localparam int MASK_W      = `DATA_WIDTH / 8;
  // Address bits between the vcache x field and the region code
  localparam int VC_POD_RAW_W = `PADDR_WIDTH - 2 - `VCACHE_ADDR_WIDTH - `X_CORD_WIDTH;

  logic [1:0]                  region;
  logic [`MC_ADDR_WIDTH-1:0]   tile_epa;
  logic [`X_CORD_WIDTH-1:0]    tile_x;
  logic [`Y_CORD_WIDTH-1:0]    tile_y;
  logic [`MC_ADDR_WIDTH-1:0]   vc_epa;
  logic [`X_CORD_WIDTH-1:0]    vc_x;
  logic [VC_POD_RAW_W-1:0]     vc_pod_raw;
  logic [`POD_Y_WIDTH-1:0]     vc_pod_y;
  logic [`Y_SUBCORD_WIDTH-1:0] vc_sub_y;
  logic [`MC_ADDR_WIDTH-1:0]   host_epa;
  logic [MASK_W-1:0]           store_mask;

  ////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////

  assign region   = hdr_i.addr[`PADDR_WIDTH-1 -: 2];

  assign tile_epa = `MC_ADDR_WIDTH'(hdr_i.addr[2 +: `TILE_ADDR_WIDTH-2]);
  assign tile_x   = hdr_i.addr[`TILE_ADDR_WIDTH +: `X_CORD_WIDTH];
  assign tile_y   = hdr_i.addr[`TILE_ADDR_WIDTH+`X_CORD_WIDTH +: `Y_CORD_WIDTH];

  assign vc_epa     = `MC_ADDR_WIDTH'(hdr_i.addr[2 +: `VCACHE_ADDR_WIDTH-2]);
  assign vc_x       = hdr_i.addr[`VCACHE_ADDR_WIDTH +: `X_CORD_WIDTH];
  assign vc_pod_raw = hdr_i.addr[`PADDR_WIDTH-3 -: VC_POD_RAW_W];
  // Vcache pods sit on even rows, so the low pod bit is always zero
  assign vc_pod_y   = `POD_Y_WIDTH'(vc_pod_raw) << 1;
  // North or south edge of the pod
  assign vc_sub_y   = (vc_pod_y[1] == 1'b0) ? '1 : '0;

  assign host_epa = hdr_i.addr[2 +: `MC_ADDR_WIDTH];

  // Byte lanes touched by a store
  always_comb
  begin
    case (hdr_i.size)
      e_bedrock_msg_size_1: store_mask = MASK_W'(4'h1) << hdr_i.addr[1:0];
      e_bedrock_msg_size_2: store_mask = MASK_W'(4'h3) << hdr_i.addr[1:0];
      default:              store_mask = MASK_W'(4'hf) << hdr_i.addr[1:0];
    endcase
  end

  ////////////////////////////////////////
  // Packet build
  ////////////////////////////////////////

  always_comb
  begin
    packet_o            = '0;
    packet_o.src_x_cord = global_x_i;
    packet_o.src_y_cord = global_y_i;
    packet_o.reg_id     = {{(`REG_ID_WIDTH-`TRANS_ID_WIDTH){1'b0}}, alloc_id_i};

    if (region == `REGION_TILE)
    begin
      packet_o.addr   = tile_epa;
      packet_o.x_cord = tile_x;
      packet_o.y_cord = tile_y;
    end
    else if (region == `REGION_VCACHE)
    begin
      packet_o.addr   = vc_epa;
      packet_o.x_cord = vc_x;
      packet_o.y_cord = {vc_pod_y, vc_sub_y};
    end
    else
    begin
      packet_o.addr   = host_epa;
      packet_o.x_cord = host_x_i;
      packet_o.y_cord = host_y_i;
    end

    case (hdr_i.msg_type)
      e_bedrock_mem_uc_rd, e_bedrock_mem_rd:
      begin
        packet_o.op                   = e_remote_load;
        packet_o.load_info.is_byte_op = (hdr_i.size == e_bedrock_msg_size_1);
        packet_o.load_info.is_hex_op  = (hdr_i.size == e_bedrock_msg_size_2);
        packet_o.load_info.part_sel   = hdr_i.addr[1:0];
      end
      e_bedrock_mem_amo:
      begin
        packet_o.payload = data_i[`DATA_WIDTH-1:0];
        case (hdr_i.subop)
          e_bedrock_amoadd: packet_o.op = e_remote_amoadd;
          e_bedrock_amoor:  packet_o.op = e_remote_amoor;
          default:          packet_o.op = e_remote_amoswap;
        endcase
      end
      // uc_wr and wr
      default:
      begin
        packet_o.payload    = data_i[`DATA_WIDTH-1:0];
        packet_o.store_mask = store_mask;
        packet_o.op         = (store_mask == '1) ? e_remote_store : e_remote_sw;
      end
    endcase
  end

endmodule

/* rtl/slot_mem.sv */
`timescale 1ns/100ps
`include "mmio_defs.svh"

module slot_mem
  #(
    parameter type payload_t = logic [`DATA_WIDTH-1:0]
  )
  (
    input  logic                       clk_i,

    input  logic                       w_v_i,
    input  logic [`TRANS_ID_WIDTH-1:0] w_id_i,
    input  payload_t                   w_data_i,

    input  logic [`TRANS_ID_WIDTH-1:0] r_id_i,
    output payload_t                   r_data_o
  );

  // One entry per transaction id
  payload_t mem_r [`OUTSTANDING];

  always_ff @(posedge clk_i)
  begin
    if (w_v_i)
    begin
      mem_r[w_id_i] <= w_data_i;
    end
  end

  // Asynchronous read, the owner checks the slot state
  assign r_data_o = mem_r[r_id_i];

endmodule

/* rtl/txn_tracker.sv */
`timescale 1ns/100ps
`include "mmio_defs.svh"

module txn_tracker
  (
    input  logic                        clk_i,
    input  logic                        rst_n_i,

    // Allocation side
    input  logic                        alloc_take_i,
    input  bedrock_pkg::bedrock_hdr_t   alloc_hdr_i,
    output logic [`TRANS_ID_WIDTH-1:0]  alloc_id_o,
    output logic                        alloc_free_o,

    // Mesh returns
    input  logic                        ret_v_i,
    input  logic [`TRANS_ID_WIDTH-1:0]  ret_id_i,
    input  logic [`DATA_WIDTH-1:0]      ret_data_i,

    // In-order retire
    output logic                        rev_v_o,
    output bedrock_pkg::bedrock_hdr_t   rev_hdr_o,
    output logic [`DATA_WIDTH-1:0]      rev_word_o,
    input  logic                        rev_take_i
  );

  import bedrock_pkg::*;

  logic [`TRANS_ID_WIDTH-1:0] alloc_ptr_r;
  logic [`TRANS_ID_WIDTH-1:0] retire_ptr_r;
  logic [`OUTSTANDING-1:0]    busy_r;
  logic [`OUTSTANDING-1:0]    done_r;

  ////////////////////////////////////////
  // Slot state
  ////////////////////////////////////////

  // Next slot handed out must be idle
  assign alloc_id_o   = alloc_ptr_r;
  assign alloc_free_o = ~busy_r[alloc_ptr_r];

  // Oldest slot retires only once its return has landed
  assign rev_v_o = busy_r[retire_ptr_r] & done_r[retire_ptr_r];

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      alloc_ptr_r  <= '0;
      retire_ptr_r <= '0;
      busy_r       <= '0;
      done_r       <= '0;
    end
    else
    begin
      if (alloc_take_i)
      begin
        busy_r[alloc_ptr_r] <= 1'b1;
        alloc_ptr_r         <= alloc_ptr_r + 1'b1;
      end

      // Stores return a credit, which also marks them done
      if (ret_v_i)
      begin
        done_r[ret_id_i] <= 1'b1;
      end

      if (rev_take_i)
      begin
        busy_r[retire_ptr_r] <= 1'b0;
        done_r[retire_ptr_r] <= 1'b0;
        retire_ptr_r         <= retire_ptr_r + 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // Per-slot storage
  ////////////////////////////////////////

  slot_mem #(.payload_t(bedrock_hdr_t)) header_store
  (
    .clk_i    (clk_i),
    .w_v_i    (alloc_take_i),
    .w_id_i   (alloc_ptr_r),
    .w_data_i (alloc_hdr_i),
    .r_id_i   (retire_ptr_r),
    .r_data_o (rev_hdr_o)
  );

  slot_mem #(.payload_t(logic [`DATA_WIDTH-1:0])) data_store
  (
    .clk_i    (clk_i),
    .w_v_i    (ret_v_i),
    .w_id_i   (ret_id_i),
    .w_data_i (ret_data_i),
    .r_id_i   (retire_ptr_r),
    .r_data_o (rev_word_o)
  );

endmodule

/* rtl/rev_formatter.sv */
`timescale 1ns/100ps
`include "mmio_defs.svh"

module rev_formatter
  (
    input  logic                       rev_v_i,
    input  bedrock_pkg::bedrock_hdr_t  rev_hdr_i,
    input  logic [`DATA_WIDTH-1:0]     rev_word_i,
    output logic                       rev_take_o,

    output bedrock_pkg::bedrock_hdr_t  mem_rev_header_o,
    output logic [`FILL_WIDTH-1:0]     mem_rev_data_o,
    output logic                       mem_rev_v_o,
    input  logic                       mem_rev_ready_i
  );

  import bedrock_pkg::*;

  // Response carries the request header back
  assign mem_rev_header_o = rev_hdr_i;
  assign mem_rev_v_o      = rev_v_i;
  assign rev_take_o       = rev_v_i & mem_rev_ready_i;

  // Replicate the low bytes across the whole bus
  always_comb
  begin
    case (rev_hdr_i.size)
      e_bedrock_msg_size_1:
        mem_rev_data_o = {(`FILL_WIDTH/8){rev_word_i[7:0]}};
      e_bedrock_msg_size_2:
        mem_rev_data_o = {(`FILL_WIDTH/16){rev_word_i[15:0]}};
      // Mesh word is the widest access, 8 bytes falls back to 4
      default:
        mem_rev_data_o = {(`FILL_WIDTH/`DATA_WIDTH){rev_word_i}};
    endcase
  end

endmodule

/* rtl/mmio_bridge.sv */
`timescale 1ns/100ps
`include "mmio_defs.svh"

module mmio_bridge
  (
    input  logic                          clk_i,
    input  logic                          rst_n_i,

    // Processor request
    input  bedrock_pkg::bedrock_hdr_t     mem_fwd_header_i,
    input  logic [`FILL_WIDTH-1:0]        mem_fwd_data_i,
    input  logic                          mem_fwd_v_i,
    output logic                          mem_fwd_ready_o,

    // Mesh request
    output manycore_pkg::mc_packet_t      mc_req_o,
    output logic                          mc_req_v_o,
    input  logic                          mc_req_ready_i,

    // Mesh return
    input  manycore_pkg::mc_return_t      mc_ret_i,
    input  logic                          mc_ret_v_i,

    // Processor response
    output bedrock_pkg::bedrock_hdr_t     mem_rev_header_o,
    output logic [`FILL_WIDTH-1:0]        mem_rev_data_o,
    output logic                          mem_rev_v_o,
    input  logic                          mem_rev_ready_i,

    input  logic [`X_CORD_WIDTH-1:0]      host_x_i,
    input  logic [`Y_CORD_WIDTH-1:0]      host_y_i,
    input  logic [`X_CORD_WIDTH-1:0]      global_x_i,
    input  logic [`Y_CORD_WIDTH-1:0]      global_y_i
  );

  import bedrock_pkg::*;

  logic [`TRANS_ID_WIDTH-1:0] alloc_id;
  logic                       alloc_free;
  logic                       alloc_take;
  logic                       rev_v;
  bedrock_hdr_t               rev_hdr;
  logic [`DATA_WIDTH-1:0]     rev_word;
  logic                       rev_take;

  ////////////////////////////////////////
  // Request path
  ////////////////////////////////////////

  // Needs a free slot and room in the mesh
  assign mem_fwd_ready_o = alloc_free & mc_req_ready_i;
  assign alloc_take      = mem_fwd_ready_o & mem_fwd_v_i;
  assign mc_req_v_o      = alloc_take;

  fwd_decoder u_fwd_decoder
  (
    .hdr_i      (mem_fwd_header_i),
    .data_i     (mem_fwd_data_i),
    .alloc_id_i (alloc_id),
    .host_x_i   (host_x_i),
    .host_y_i   (host_y_i),
    .global_x_i (global_x_i),
    .global_y_i (global_y_i),
    .packet_o   (mc_req_o)
  );

  ////////////////////////////////////////
  // Tracking and response path
  ////////////////////////////////////////

  txn_tracker u_txn_tracker
  (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .alloc_take_i (alloc_take),
    .alloc_hdr_i  (mem_fwd_header_i),
    .alloc_id_o   (alloc_id),
    .alloc_free_o (alloc_free),
    .ret_v_i      (mc_ret_v_i),
    // Low reg_id bits are the slot
    .ret_id_i     (mc_ret_i.reg_id[`TRANS_ID_WIDTH-1:0]),
    .ret_data_i   (mc_ret_i.data),
    .rev_v_o      (rev_v),
    .rev_hdr_o    (rev_hdr),
    .rev_word_o   (rev_word),
    .rev_take_i   (rev_take)
  );

  rev_formatter u_rev_formatter
  (
    .rev_v_i          (rev_v),
    .rev_hdr_i        (rev_hdr),
    .rev_word_i       (rev_word),
    .rev_take_o       (rev_take),
    .mem_rev_header_o (mem_rev_header_o),
    .mem_rev_data_o   (mem_rev_data_o),
    .mem_rev_v_o      (mem_rev_v_o),
    .mem_rev_ready_i  (mem_rev_ready_i)
  );

endmodule

/* test/tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen
  #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 4
  )
  (
    output logic clk_o,
    output logic rst_n_o
  );

  initial
  begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Reset held low, released on a rising edge
  initial
  begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

/* test/tb_mmio_bridge.sv */
`timescale 1ns/100ps
`include "mmio_defs.svh"

module tb_mmio_bridge;

  import bedrock_pkg::*;
  import manycore_pkg::*;

  localparam int NUM_ROWS   = 14;
  localparam int STALL_ROW  = 9;
  localparam int TIMEOUT_NS = NUM_ROWS * 200;
  localparam logic [`X_CORD_WIDTH-1:0] HOST_X   = 7'h10;
  localparam logic [`Y_CORD_WIDTH-1:0] HOST_Y   = 7'h01;
  localparam logic [`X_CORD_WIDTH-1:0] GLOBAL_X = 7'h05;
  localparam logic [`Y_CORD_WIDTH-1:0] GLOBAL_Y = 7'h02;

  // One request and everything expected from it
  typedef struct packed
  {
    bedrock_msg_e              msg;
    bedrock_amo_e              subop;
    bedrock_size_e             size;
    logic [`PADDR_WIDTH-1:0]   addr;
    logic [`FILL_WIDTH-1:0]    data;
    logic [`X_CORD_WIDTH-1:0]  x;
    logic [`Y_CORD_WIDTH-1:0]  y;
    logic [`MC_ADDR_WIDTH-1:0] epa;
    mc_op_e                    op;
    logic [3:0]                mask;
    logic [3:0]                linfo;
    logic [`DATA_WIDTH-1:0]    ret_word;
    logic [`FILL_WIDTH-1:0]    rsp_data;
  } row_t;

  logic                   clk;
  logic                   rst_n;
  bedrock_hdr_t           mem_fwd_header_i;
  logic [`FILL_WIDTH-1:0] mem_fwd_data_i;
  logic                   mem_fwd_v_i;
  logic                   mem_fwd_ready_o;
  mc_packet_t             mc_req_o;
  logic                   mc_req_v_o;
  logic                   mc_req_ready_i;
  mc_return_t             mc_ret_i;
  logic                   mc_ret_v_i;
  bedrock_hdr_t           mem_rev_header_o;
  logic [`FILL_WIDTH-1:0] mem_rev_data_o;
  logic                   mem_rev_v_o;
  logic                   mem_rev_ready_i;

  row_t                   rows [NUM_ROWS];
  int                     row_cnt   = 0;
  int                     req_cnt   = 0;
  int                     rsp_cnt   = 0;
  int                     err_cnt   = 0;
  int                     check_cnt = 0;
  integer                 seed      = 32'h2f22;
  logic                   stall;
  logic                   held;
  bedrock_hdr_t           held_hdr;
  logic [`FILL_WIDTH-1:0] held_data;
  int                     pend_row [$];
  logic [4:0]             pend_id [$];

  tb_clock_gen u_clock_gen
  (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  mmio_bridge u_mmio_bridge
  (
    .clk_i            (clk),
    .rst_n_i          (rst_n),
    .mem_fwd_header_i (mem_fwd_header_i),
    .mem_fwd_data_i   (mem_fwd_data_i),
    .mem_fwd_v_i      (mem_fwd_v_i),
    .mem_fwd_ready_o  (mem_fwd_ready_o),
    .mc_req_o         (mc_req_o),
    .mc_req_v_o       (mc_req_v_o),
    .mc_req_ready_i   (mc_req_ready_i),
    .mc_ret_i         (mc_ret_i),
    .mc_ret_v_i       (mc_ret_v_i),
    .mem_rev_header_o (mem_rev_header_o),
    .mem_rev_data_o   (mem_rev_data_o),
    .mem_rev_v_o      (mem_rev_v_o),
    .mem_rev_ready_i  (mem_rev_ready_i),
    .host_x_i         (HOST_X),
    .host_y_i         (HOST_Y),
    .global_x_i       (GLOBAL_X),
    .global_y_i       (GLOBAL_Y)
  );

  ////////////////////////////////////////
  // Table and helpers
  ////////////////////////////////////////

  task automatic add_row(input bedrock_msg_e msg, input bedrock_amo_e subop,
                         input bedrock_size_e size, input logic [39:0] addr,
                         input logic [63:0] data, input logic [6:0] x, input logic [6:0] y,
                         input logic [27:0] epa, input mc_op_e op, input logic [3:0] mask,
                         input logic [3:0] linfo, input logic [31:0] ret_word,
                         input logic [63:0] rsp_data);
    rows[row_cnt] = '{msg, subop, size, addr, data, x, y, epa, op, mask, linfo,
                      ret_word, rsp_data};
    row_cnt++;
  endtask

  task automatic fill_table();
    // Tile loads of a word, a byte and a half-word
    add_row(e_bedrock_mem_uc_rd, e_bedrock_amoswap, e_bedrock_msg_size_4, 40'hc0_120c_1234,
      64'h0, 7'd3, 7'd9, 28'h48d, e_remote_load, 4'h0, 4'h0,
      32'h1122_3344, 64'h1122_3344_1122_3344);
    add_row(e_bedrock_mem_uc_rd, e_bedrock_amoswap, e_bedrock_msg_size_1, 40'hc0_120c_1235,
      64'h0, 7'd3, 7'd9, 28'h48d, e_remote_load, 4'h0, 4'h9,
      32'h5566_77a8, 64'ha8a8_a8a8_a8a8_a8a8);
    add_row(e_bedrock_mem_rd, e_bedrock_amoswap, e_bedrock_msg_size_2, 40'hc0_120c_1236,
      64'h0, 7'd3, 7'd9, 28'h48d, e_remote_load, 4'h0, 4'h6,
      32'h0000_beef, 64'hbeef_beef_beef_beef);
    // Vcache with pod bit 1 clear, then set
    add_row(e_bedrock_mem_uc_rd, e_bedrock_amoswap, e_bedrock_msg_size_4, 40'h80_a000_0100,
      64'h0, 7'd5, 7'h07, 28'h40, e_remote_load, 4'h0, 4'h0,
      32'hcafe_0001, 64'hcafe_0001_cafe_0001);
    add_row(e_bedrock_mem_uc_rd, e_bedrock_amoswap, e_bedrock_msg_size_4, 40'h90_4000_0020,
      64'h0, 7'd2, 7'h10, 28'h8, e_remote_load, 4'h0, 4'h0,
      32'h0bad_f00d, 64'h0bad_f00d_0bad_f00d);
    // Atomics
    add_row(e_bedrock_mem_amo, e_bedrock_amoadd, e_bedrock_msg_size_4, 40'hc0_120c_1240,
      64'hffff_ffff_0000_0005, 7'd3, 7'd9, 28'h490, e_remote_amoadd, 4'h0, 4'h0,
      32'h0000_0010, 64'h0000_0010_0000_0010);
    add_row(e_bedrock_mem_amo, e_bedrock_amoor, e_bedrock_msg_size_4, 40'h80_a000_0104,
      64'h0000_0000_0000_00f0, 7'd5, 7'h07, 28'h41, e_remote_amoor, 4'h0, 4'h0,
      32'h0000_000f, 64'h0000_000f_0000_000f);
    add_row(e_bedrock_mem_amo, e_bedrock_amoswap, e_bedrock_msg_size_4, 40'h00_0000_1008,
      64'h1234_5678_dead_beef, HOST_X, HOST_Y, 28'h402, e_remote_amoswap, 4'h0, 4'h0,
      32'h7777_0000, 64'h7777_0000_7777_0000);
    add_row(e_bedrock_mem_uc_wr, e_bedrock_amoswap, e_bedrock_msg_size_4, 40'hc0_120c_1234,
      64'h0000_0000_a5a5_5a5a, 7'd3, 7'd9, 28'h48d, e_remote_store, 4'hf, 4'h0,
      32'h0, 64'h0);
    // Four requests of the stall group fill every slot
    add_row(e_bedrock_mem_uc_wr, e_bedrock_amoswap, e_bedrock_msg_size_1, 40'h40_0000_0012,
      64'h0000_0000_0000_00ab, HOST_X, HOST_Y, 28'h4, e_remote_sw, 4'h4, 4'h0,
      32'h0, 64'h0);
    add_row(e_bedrock_mem_wr, e_bedrock_amoswap, e_bedrock_msg_size_2, 40'h90_4000_0020,
      64'h0000_0000_0000_1357, 7'd2, 7'h10, 28'h8, e_remote_sw, 4'h3, 4'h0,
      32'h0, 64'h0);
    add_row(e_bedrock_mem_uc_rd, e_bedrock_amoswap, e_bedrock_msg_size_2, 40'hb0_2000_0002,
      64'h0, 7'd1, 7'h30, 28'h0, e_remote_load, 4'h0, 4'h6,
      32'h0000_4321, 64'h4321_4321_4321_4321);
    add_row(e_bedrock_mem_uc_rd, e_bedrock_amoswap, e_bedrock_msg_size_1, 40'h00_0000_2003,
      64'h0, HOST_X, HOST_Y, 28'h800, e_remote_load, 4'h0, 4'hb,
      32'h0000_005a, 64'h5a5a_5a5a_5a5a_5a5a);
    // Eight-byte read comes back as a replicated word
    add_row(e_bedrock_mem_uc_rd, e_bedrock_amoswap, e_bedrock_msg_size_8, 40'hc0_120c_1238,
      64'h0, 7'd3, 7'd9, 28'h48e, e_remote_load, 4'h0, 4'h0,
      32'h89ab_cdef, 64'h89ab_cdef_89ab_cdef);
  endtask

  function automatic bedrock_hdr_t row_header(input int idx);
    bedrock_hdr_t hdr;
    hdr.msg_type = rows[idx].msg;
    hdr.subop    = rows[idx].subop;
    hdr.size     = rows[idx].size;
    hdr.addr     = rows[idx].addr;
    hdr.tag      = 16'h00a0 + 16'(idx);
    return hdr;
  endfunction

  task automatic check_value(input logic [127:0] actual, input logic [127:0] expected,
                             input string what);
    check_cnt++;
    if (actual !== expected)
    begin
      err_cnt++;
      $display("CHECK FAILED at %0t: %s, got %0h, expected %0h", $time, what, actual, expected);
    end
  endtask

  task automatic check_packet(input int idx);
    logic  is_read;
    string tag;
    is_read = (rows[idx].msg == e_bedrock_mem_uc_rd) || (rows[idx].msg == e_bedrock_mem_rd);
    tag     = $sformatf("request %0d", idx);
    check_value(mc_req_o.x_cord, rows[idx].x, {tag, " dest x"});
    check_value(mc_req_o.y_cord, rows[idx].y, {tag, " dest y"});
    check_value(mc_req_o.addr, rows[idx].epa, {tag, " word address"});
    check_value(mc_req_o.op, rows[idx].op, {tag, " op"});
    check_value(mc_req_o.store_mask, rows[idx].mask, {tag, " store mask"});
    check_value(mc_req_o.load_info, rows[idx].linfo, {tag, " load info"});
    check_value(mc_req_o.payload, is_read ? 32'h0 : rows[idx].data[31:0], {tag, " payload"});
    // Ids are handed out in order
    check_value(mc_req_o.reg_id, `REG_ID_WIDTH'(idx % `OUTSTANDING), {tag, " reg id"});
    check_value({mc_req_o.src_x_cord, mc_req_o.src_y_cord}, {GLOBAL_X, GLOBAL_Y},
                {tag, " source"});
  endtask

  ////////////////////////////////////////
  // Mesh model
  ////////////////////////////////////////

  always @(posedge clk)
  begin
    int   k;
    row_t r;
    if (!rst_n)
    begin
      mc_ret_v_i      <= 1'b0;
      mc_req_ready_i  <= 1'b1;
      mem_rev_ready_i <= 1'b0;
    end
    else
    begin
      if (mc_req_v_o)
      begin
        if (req_cnt >= NUM_ROWS)
        begin
          $display("ERROR at %0t: mesh request with no matching table row", $time);
          err_cnt++;
        end
        else
        begin
          check_packet(req_cnt);
          pend_row.push_back(req_cnt);
          pend_id.push_back(mc_req_o.reg_id);
        end
        req_cnt++;
      end
      // Answer one outstanding request now and then, in any order
      mc_ret_v_i <= 1'b0;
      if ((pend_row.size() != 0) && (($random(seed) & 1) != 0))
      begin
        k = $unsigned($random(seed)) % pend_row.size();
        r = rows[pend_row[k]];
        mc_ret_v_i      <= 1'b1;
        mc_ret_i.reg_id <= pend_id[k];
        mc_ret_i.data   <= r.ret_word;
        if ((r.msg == e_bedrock_mem_uc_wr) || (r.msg == e_bedrock_mem_wr))
          mc_ret_i.pkt_type <= e_return_credit;
        else
          mc_ret_i.pkt_type <= e_return_int_wb;
        pend_row.delete(k);
        pend_id.delete(k);
      end
      mc_req_ready_i  <= stall || (($random(seed) & 7) != 0);
      mem_rev_ready_i <= !stall && (($random(seed) & 3) != 0);
    end
  end

  ////////////////////////////////////////
  // Response monitor
  ////////////////////////////////////////

  always @(posedge clk)
  begin
    if (rst_n)
    begin
      if (held)
      begin
        check_value(mem_rev_v_o, 1'b1, "response valid dropped before transfer");
        check_value(mem_rev_header_o, held_hdr, "response header moved while held");
        check_value(mem_rev_data_o, held_data, "response data moved while held");
      end
      held      = mem_rev_v_o && !mem_rev_ready_i;
      held_hdr  = mem_rev_header_o;
      held_data = mem_rev_data_o;
      if (!mc_req_ready_i)
        check_value(mem_fwd_ready_o, 1'b0, "fwd ready while mesh not ready");
      if (mem_rev_v_o && mem_rev_ready_i)
      begin
        if (rsp_cnt >= NUM_ROWS)
        begin
          $display("ERROR at %0t: response with no outstanding request", $time);
          err_cnt++;
        end
        else
        begin
          check_value(mem_rev_header_o, row_header(rsp_cnt),
                      $sformatf("response %0d header", rsp_cnt));
          check_value(mem_rev_data_o, rows[rsp_cnt].rsp_data,
                      $sformatf("response %0d data", rsp_cnt));
        end
        rsp_cnt++;
      end
    end
  end

  ////////////////////////////////////////
  // Request driver
  ////////////////////////////////////////

  initial
  begin
    int i;
    mem_fwd_header_i = '0;
    mem_fwd_data_i   = '0;
    mem_fwd_v_i      = 1'b0;
    mc_req_ready_i   = 1'b1;
    mc_ret_i         = '0;
    mc_ret_v_i       = 1'b0;
    mem_rev_ready_i  = 1'b0;
    stall            = 1'b0;
    held             = 1'b0;
    fill_table();
    wait (rst_n);
    @(posedge clk);
    check_value(mem_rev_v_o, 1'b0, "response valid after reset");
    check_value(mc_req_v_o, 1'b0, "mesh request valid after reset");
    for (i = 0; i < NUM_ROWS; i++)
    begin
      // Drain with the request bus idle, then hold the response side off
      if (i == STALL_ROW)
      begin
        mem_fwd_v_i <= 1'b0;
        while (rsp_cnt < STALL_ROW)
          @(posedge clk);
        stall <= 1'b1;
      end
      mem_fwd_header_i <= row_header(i);
      mem_fwd_data_i   <= rows[i].data;
      mem_fwd_v_i      <= 1'b1;
      // Four slots held, so this request has to wait for a response
      if (i == STALL_ROW + `OUTSTANDING)
      begin
        while (pend_row.size() != 0)
          @(posedge clk);
        @(posedge clk);
        repeat (4)
        begin
          @(posedge clk);
          check_value(mem_fwd_ready_o, 1'b0, "fwd ready with all slots busy");
          check_value(mem_rev_v_o, 1'b1, "oldest response valid during stall");
        end
        stall <= 1'b0;
      end
      @(posedge clk);
      while (!mem_fwd_ready_o)
        @(posedge clk);
    end
    mem_fwd_v_i <= 1'b0;
    while (rsp_cnt < NUM_ROWS)
      @(posedge clk);
    repeat (4) @(posedge clk);
    check_value(mem_rev_v_o, 1'b0, "response valid with nothing outstanding");
    check_value(req_cnt, NUM_ROWS, "mesh request count");
    $display("Checks: %0d, errors: %0d, responses: %0d of %0d",
             check_cnt, err_cnt, rsp_cnt, NUM_ROWS);
    if (err_cnt == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

  // Watchdog
  initial
  begin
    #(TIMEOUT_NS);
    $display("ERROR: run timed out after %0d ns with %0d of %0d responses",
             TIMEOUT_NS, rsp_cnt, NUM_ROWS);
    $display("TEST FAIL");
    $finish;
  end

endmodule

/* filelist.f */
+incdir+rtl
rtl/bedrock_pkg.sv
rtl/manycore_pkg.sv
rtl/fwd_decoder.sv
rtl/slot_mem.sv
rtl/txn_tracker.sv
rtl/rev_formatter.sv
rtl/mmio_bridge.sv
test/tb_clock_gen.sv
test/tb_mmio_bridge.sv
